// ==== common/tracking_pkg.sv ====
`default_nettype none

package tracking_pkg;

	// memory side
	typedef logic [17:0] mem_addr_t;   // main memory and pointer memory address
	typedef logic [31:0] mem_word_t;   // one record word

	// packet side
	typedef logic [7:0] byte_t;
	typedef logic [5:0] buf_addr_t;    // 64 byte packet buffer
	typedef logic [4:0] slot_idx_t;    // pointer slot index

	typedef enum logic [2:0] {
		RED    = 3'd0,
		ORANGE = 3'd1,
		YELLOW = 3'd2,
		GREEN  = 3'd3,
		BLUE   = 3'd4,
		PURPLE = 3'd5
	} color_t;

	typedef enum logic {
		RANK_1 = 1'b0,
		RANK_2 = 1'b1
	} rank_t;

	// mode 1 is red, green and blue only
	typedef enum logic {
		MODE_RGB       = 1'b0,
		MODE_SIX_COLOR = 1'b1
	} tracking_mode_t;

	localparam int NUM_COLORS     = 6;
	localparam int SLOTS_PER_RANK = 6;   // slots 0-5 rank 1, 6-11 rank 2
	localparam int PTR_SLOTS      = 12;

	// empty pointer slot
	localparam mem_addr_t INVALID_POINTER = '1;

	// packet framing
	localparam byte_t SOF_MARKER      = 8'd176;
	localparam byte_t LINE_FEED       = 8'd10;
	localparam byte_t CARRIAGE_RETURN = 8'd13;

	localparam byte_t PROTOCOL_RGB       = 8'd1;
	localparam byte_t PROTOCOL_SIX_COLOR = 8'd2;

endpackage

`default_nettype wire

// ==== verilog/tracking_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_buffer import tracking_pkg::*; #(
	parameter int DEPTH = 64
) (
	input wire logic clk,
	input wire logic wren_a,
	input wire logic [$clog2(DEPTH)-1:0] addr_a,
	input wire byte_t data_a,
	input wire logic [$clog2(DEPTH)-1:0] addr_b,
	output byte_t data_b
);

	byte_t mem [DEPTH];

	// port a is write only, filled by the packet writer
	always_ff @(posedge clk) begin
		if (wren_a)
			mem[addr_a] <= data_a;
	end

	// port b read data arrives one cycle after the address
	always_ff @(posedge clk) begin
		data_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

// ==== verilog/color_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_tracker import tracking_pkg::*; #(
	parameter color_t COLOR = RED
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic run_start,
	input wire logic capture,
	input wire color_t capture_color,
	input wire rank_t capture_rank,
	input wire byte_t blob_x,
	input wire byte_t blob_y,
	input wire logic [15:0] blob_size,
	output logic [1:0] valid,
	output byte_t [1:0] x,
	output byte_t [1:0] y,
	output logic [1:0][15:0] size
);

	logic hit;

	assign hit = capture && (capture_color == COLOR);

	always_ff @(posedge clk) begin
		if (reset || run_start) begin
			valid <= '0;
		end else if (hit) begin
			valid[capture_rank] <= 1'b1;
		end
	end

	// a later blob of the same rank simply replaces the earlier one
	always_ff @(posedge clk) begin
		if (hit) begin
			x[capture_rank] <= blob_x;
			y[capture_rank] <= blob_y;
			size[capture_rank] <= blob_size;
		end
	end

endmodule

`default_nettype wire

// ==== blob_fetch/blob_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module blob_fetcher import tracking_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable_tracking_output,
	input wire logic [4:0] number_of_valid_blobs,
	input wire mem_addr_t blob_pointer,
	input wire mem_word_t data_read,
	output slot_idx_t pointer_addr,
	output mem_addr_t address,
	output logic run_active,
	output logic run_start,
	output logic scan_done,
	output logic capture,
	output color_t capture_color,
	output rank_t capture_rank,
	output byte_t blob_x,
	output byte_t blob_y,
	output logic [15:0] blob_size,
	output logic [5:0] tracking_display
);

	// both memories answer one cycle after the address, hence the wait states
	typedef enum logic [3:0] {
		S_IDLE,
		S_PTR_WAIT,
		S_PTR_CHECK,
		S_W1_WAIT,
		S_W1,
		S_W2_WAIT,
		S_W2,
		S_NEXT,
		S_DONE
	} state_t;

	state_t state;
	logic [4:0] fetched;       // blobs read so far this run
	byte_t color_code;         // record color, already shifted to 0-based
	logic color_ok;

	assign color_ok = color_code < 8'(NUM_COLORS);

	always_ff @(posedge clk) begin
		run_start <= 1'b0;
		capture <= 1'b0;
		scan_done <= 1'b0;
		if (reset || !enable_tracking_output) begin
			state <= S_IDLE;
			run_active <= 1'b0;
			pointer_addr <= '0;
			fetched <= '0;
			tracking_display <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					run_active <= 1'b1;
					run_start <= 1'b1;   // trackers drop last run's blobs
					pointer_addr <= '0;
					fetched <= '0;
					tracking_display <= '0;
					state <= S_PTR_WAIT;
				end
				S_PTR_WAIT: state <= S_PTR_CHECK;
				S_PTR_CHECK: begin
					if (fetched == number_of_valid_blobs) begin
						scan_done <= 1'b1;   // count reached, stop early
						state <= S_DONE;
					end else if (blob_pointer == INVALID_POINTER) begin
						state <= S_NEXT;
					end else begin
						state <= S_W1_WAIT;
					end
				end
				S_W1_WAIT: state <= S_W1;
				S_W1: state <= S_W2_WAIT;
				S_W2_WAIT: state <= S_W2;
				S_W2: begin
					fetched <= fetched + 5'd1;
					if (color_ok) begin
						capture <= 1'b1;
						tracking_display[color_code[2:0]] <= 1'b1;
					end
					state <= S_NEXT;
				end
				S_NEXT: begin
					if (pointer_addr == slot_idx_t'(PTR_SLOTS - 1)) begin
						scan_done <= 1'b1;
						state <= S_DONE;
					end else begin
						pointer_addr <= pointer_addr + 5'd1;
						state <= S_PTR_WAIT;
					end
				end
				S_DONE: state <= S_DONE;   // held until enable drops
				default: state <= S_IDLE;
			endcase
		end
	end

	// record fields, word one then word two
	always_ff @(posedge clk) begin
		case (state)
			S_PTR_CHECK: address <= blob_pointer;
			S_W1: begin
				color_code <= data_read[7:0] - 8'd1;
				address <= address + 18'd1;
			end
			S_W2: begin
				blob_x <= data_read[31:24];
				blob_y <= data_read[23:16];
				blob_size <= data_read[15:0];
				capture_color <= color_t'(color_code[2:0]);
				capture_rank <= (pointer_addr < slot_idx_t'(SLOTS_PER_RANK)) ? RANK_1 : RANK_2;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== packet_writer/packet_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_writer import tracking_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic run_active,
	input wire logic scan_done,
	input wire logic [1:0] tracking_mode_select,
	input wire logic [NUM_COLORS-1:0][1:0] obj_valid,
	input wire byte_t [NUM_COLORS-1:0][1:0] obj_x,
	input wire byte_t [NUM_COLORS-1:0][1:0] obj_y,
	input wire logic [NUM_COLORS-1:0][1:0][15:0] obj_size,
	output logic buf_wren,
	output buf_addr_t buf_addr,
	output byte_t buf_data,
	output logic [6:0] number_of_bytes_to_transmit,
	output logic tracking_done
);

	tracking_mode_t mode;
	logic [6:0] obj_count;    // objects in the packet, 6 or 12
	logic [6:0] half_count;   // objects per rank

	assign obj_count = (mode == MODE_RGB) ? 7'd6 : 7'd12;
	assign half_count = obj_count >> 1;

	// one byte per cycle, address 0 first
	always_ff @(posedge clk) begin
		if (reset || !run_active) begin
			buf_wren <= 1'b0;
			buf_addr <= '0;
			tracking_done <= 1'b0;
			number_of_bytes_to_transmit <= '0;
			mode <= MODE_SIX_COLOR;
		end else if (scan_done) begin
			buf_wren <= 1'b1;
			buf_addr <= '0;
			if (tracking_mode_select == 2'b01) begin
				mode <= MODE_RGB;
				number_of_bytes_to_transmit <= 7'd28;
			end else begin
				mode <= MODE_SIX_COLOR;
				number_of_bytes_to_transmit <= 7'd52;
			end
		end else if (buf_wren) begin
			if (7'(buf_addr) == number_of_bytes_to_transmit - 7'd1) begin
				buf_wren <= 1'b0;
				tracking_done <= 1'b1;   // stays up until the run ends
			end else begin
				buf_addr <= buf_addr + 6'd1;
			end
		end
	end

	// byte for the current address
	always_comb begin
		logic [6:0] a;
		logic [6:0] rel;
		logic [6:0] k;
		logic [6:0] pos;
		logic rank_sel;
		logic in_size;
		color_t col;
		a = 7'(buf_addr);
		rel = '0;
		k = '0;
		pos = '0;
		rank_sel = 1'b0;
		in_size = 1'b0;
		col = RED;
		buf_data = '0;
		if (a == 7'd0) begin
			buf_data = SOF_MARKER;
		end else if (a == 7'd1) begin
			buf_data = (mode == MODE_RGB) ? PROTOCOL_RGB : PROTOCOL_SIX_COLOR;
		end else if (a == (obj_count << 2) + 7'd2) begin
			buf_data = LINE_FEED;
		end else if (a == (obj_count << 2) + 7'd3) begin
			buf_data = CARRIAGE_RETURN;
		end else if (a < (obj_count << 2) + 7'd2) begin
			rel = a - 7'd2;
			in_size = rel >= (obj_count << 1);   // second half holds sizes
			if (in_size)
				rel = rel - (obj_count << 1);
			k = rel >> 1;
			rank_sel = k >= half_count;
			pos = rank_sel ? k - half_count : k;
			if (mode == MODE_RGB) begin
				case (pos[1:0])
					2'd0: col = RED;
					2'd1: col = GREEN;
					default: col = BLUE;
				endcase
			end else begin
				col = color_t'(pos[2:0]);
			end
			// empty objects stay zero
			if (obj_valid[col][rank_sel]) begin
				case ({in_size, rel[0]})
					2'b00: buf_data = obj_x[col][rank_sel];
					2'b01: buf_data = obj_y[col][rank_sel];
					2'b10: buf_data = obj_size[col][rank_sel][15:8];
					default: buf_data = obj_size[col][rank_sel][7:0];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tracking_output_assembly.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_output_assembly import tracking_pkg::*; #(
	parameter int BUF_DEPTH = 64
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable_tracking_output,
	input wire logic [1:0] tracking_mode_select,
	input wire mem_word_t data_read,
	input wire mem_addr_t blob_pointer,
	input wire logic [4:0] number_of_valid_blobs,
	input wire buf_addr_t tracking_output_addr_b,
	output mem_addr_t address,
	output slot_idx_t blob_pointer_addr,
	output byte_t tracking_output_data_read_b,
	output logic [6:0] number_of_bytes_to_transmit,
	output logic [5:0] tracking_display,
	output logic tracking_done
);

	logic run_active;
	logic run_start;
	logic scan_done;
	logic capture;
	color_t capture_color;
	rank_t capture_rank;
	byte_t blob_x;
	byte_t blob_y;
	logic [15:0] blob_size;

	// tracker results, indexed [color][rank]
	logic [NUM_COLORS-1:0][1:0] obj_valid;
	byte_t [NUM_COLORS-1:0][1:0] obj_x;
	byte_t [NUM_COLORS-1:0][1:0] obj_y;
	logic [NUM_COLORS-1:0][1:0][15:0] obj_size;

	logic buf_wren;
	buf_addr_t buf_addr;
	byte_t buf_data;

	blob_fetcher u_fetcher (
		.clk                    (clk),
		.reset                  (reset),
		.enable_tracking_output (enable_tracking_output),
		.number_of_valid_blobs  (number_of_valid_blobs),
		.blob_pointer           (blob_pointer),
		.data_read              (data_read),
		.pointer_addr           (blob_pointer_addr),
		.address                (address),
		.run_active             (run_active),
		.run_start              (run_start),
		.scan_done              (scan_done),
		.capture                (capture),
		.capture_color          (capture_color),
		.capture_rank           (capture_rank),
		.blob_x                 (blob_x),
		.blob_y                 (blob_y),
		.blob_size              (blob_size),
		.tracking_display       (tracking_display)
	);

	// one tracker per color, each picks out its own captures
	for (genvar c = 0; c < NUM_COLORS; c++) begin : g_tracker
		color_tracker #(
			.COLOR (color_t'(c))
		) u_tracker (
			.clk           (clk),
			.reset         (reset),
			.run_start     (run_start),
			.capture       (capture),
			.capture_color (capture_color),
			.capture_rank  (capture_rank),
			.blob_x        (blob_x),
			.blob_y        (blob_y),
			.blob_size     (blob_size),
			.valid         (obj_valid[c]),
			.x             (obj_x[c]),
			.y             (obj_y[c]),
			.size          (obj_size[c])
		);
	end

	packet_writer u_writer (
		.clk                         (clk),
		.reset                       (reset),
		.run_active                  (run_active),
		.scan_done                   (scan_done),
		.tracking_mode_select        (tracking_mode_select),
		.obj_valid                   (obj_valid),
		.obj_x                       (obj_x),
		.obj_y                       (obj_y),
		.obj_size                    (obj_size),
		.buf_wren                    (buf_wren),
		.buf_addr                    (buf_addr),
		.buf_data                    (buf_data),
		.number_of_bytes_to_transmit (number_of_bytes_to_transmit),
		.tracking_done               (tracking_done)
	);

	tracking_buffer #(
		.DEPTH (BUF_DEPTH)
	) u_buffer (
		.clk    (clk),
		.wren_a (buf_wren),
		.addr_a (buf_addr),
		.data_a (buf_data),
		.addr_b (tracking_output_addr_b),
		.data_b (tracking_output_data_read_b)
	);

endmodule

`default_nettype wire

// ==== tests/blob_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module blob_memory_model import tracking_pkg::*; #(
	parameter int WORDS = 256
) (
	input wire logic clk,
	input wire slot_idx_t pointer_addr,
	input wire mem_addr_t address,
	output mem_addr_t blob_pointer,
	output mem_word_t data_read
);

	mem_addr_t ptr_mem [32];      // only slots 0-11 are scanned
	mem_word_t main_mem [WORDS];

	initial begin
		blob_pointer <= INVALID_POINTER;
		data_read <= '0;
		for (int i = 0; i < 32; i++)
			ptr_mem[i] = INVALID_POINTER;
		for (int i = 0; i < WORDS; i++)
			main_mem[i] = {14'h3a5, 18'(i)};   // fill tied to the address
	end

	task automatic load_pointer(input int slot, input mem_addr_t ptr);
		ptr_mem[slot] = ptr;
	endtask

	task automatic load_word(input mem_addr_t addr, input mem_word_t word);
		main_mem[addr[7:0]] = word;
	endtask

	// one cycle of read latency on both memories
	always @(posedge clk) begin
		blob_pointer <= ptr_mem[pointer_addr];
		if (address < 18'(WORDS))
			data_read <= main_mem[address[7:0]];
		else
			data_read <= {14'h3a5, address};
	end

endmodule

`default_nettype wire

// ==== tests/tb_tracking_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tracking_output import tracking_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;   // five runs of about 200 cycles plus margin

	logic clk;
	logic reset;
	logic enable_tracking_output;
	logic [1:0] tracking_mode_select;
	logic [4:0] number_of_valid_blobs;
	buf_addr_t tracking_output_addr_b;
	mem_word_t data_read;
	mem_addr_t blob_pointer;
	mem_addr_t address;
	slot_idx_t blob_pointer_addr;
	byte_t tracking_output_data_read_b;
	logic [6:0] number_of_bytes_to_transmit;
	logic [5:0] tracking_display;
	logic tracking_done;

	integer seed;
	int cycles;
	int checks;
	int errors;

	// reference state, indexed [color][rank]
	bit exp_valid [NUM_COLORS][2];
	byte_t exp_x [NUM_COLORS][2];
	byte_t exp_y [NUM_COLORS][2];
	logic [15:0] exp_size [NUM_COLORS][2];
	logic [5:0] exp_display;
	byte_t exp_pkt [64];

	tracking_output_assembly dut (
		.clk                         (clk),
		.reset                       (reset),
		.enable_tracking_output      (enable_tracking_output),
		.tracking_mode_select        (tracking_mode_select),
		.data_read                   (data_read),
		.blob_pointer                (blob_pointer),
		.number_of_valid_blobs       (number_of_valid_blobs),
		.tracking_output_addr_b      (tracking_output_addr_b),
		.address                     (address),
		.blob_pointer_addr           (blob_pointer_addr),
		.tracking_output_data_read_b (tracking_output_data_read_b),
		.number_of_bytes_to_transmit (number_of_bytes_to_transmit),
		.tracking_display            (tracking_display),
		.tracking_done               (tracking_done)
	);

	blob_memory_model mem_model (
		.clk          (clk),
		.pointer_addr (blob_pointer_addr),
		.address      (address),
		.blob_pointer (blob_pointer),
		.data_read    (data_read)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, tracking_done was not seen in time", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// lay out the packet object by object from the reference records
	task automatic build_expected(input int s);
		int col;
		int k;
		for (int a = 0; a < 64; a++)
			exp_pkt[a] = '0;
		exp_pkt[0] = SOF_MARKER;
		exp_pkt[1] = (s == 6) ? PROTOCOL_RGB : PROTOCOL_SIX_COLOR;
		for (int r = 0; r < 2; r++) begin
			for (int p = 0; p < s / 2; p++) begin
				col = (s == 6) ? ((p == 0) ? 0 : p + 2) : p;   // rgb maps to 0, 3, 4
				k = r * (s / 2) + p;
				if (exp_valid[col][r]) begin
					exp_pkt[2 + 2 * k] = exp_x[col][r];
					exp_pkt[3 + 2 * k] = exp_y[col][r];
					exp_pkt[2 + 2 * s + 2 * k] = exp_size[col][r][15:8];
					exp_pkt[3 + 2 * s + 2 * k] = exp_size[col][r][7:0];
				end
			end
		end
		exp_pkt[2 + 4 * s] = LINE_FEED;
		exp_pkt[3 + 4 * s] = CARRIAGE_RETURN;
	endtask

	task automatic run_case(input logic [1:0] sel, input int nvb, input int skip_chance);
		int rnd;
		int col;
		int r;
		int fetched;
		int s;
		logic [31:0] rec;
		mem_addr_t ptr;
		fetched = 0;
		exp_display = '0;
		for (int c = 0; c < NUM_COLORS; c++) begin
			exp_valid[c][0] = 1'b0;
			exp_valid[c][1] = 1'b0;
		end
		for (int i = 0; i < PTR_SLOTS; i++) begin
			rnd = $random(seed);
			rec = $random(seed);
			col = (rnd & 32'h7fff) % NUM_COLORS;
			r = (i < SLOTS_PER_RANK) ? 0 : 1;
			ptr = 18'(32 + 4 * i);
			if (((rnd >> 16) & 15) < skip_chance)
				ptr = INVALID_POINTER;
			mem_model.load_pointer(i, ptr);
			if (ptr != INVALID_POINTER) begin
				mem_model.load_word(ptr, {24'h0, 8'(col + 1)});
				mem_model.load_word(ptr + 18'd1, rec);
				if (fetched < nvb) begin
					fetched++;
					exp_valid[col][r] = 1'b1;   // later blob of same rank overwrites
					exp_x[col][r] = rec[31:24];
					exp_y[col][r] = rec[23:16];
					exp_size[col][r] = rec[15:0];
					exp_display[col] = 1'b1;
				end
			end
		end
		s = (sel == 2'b01) ? 6 : 12;
		build_expected(s);

		@(negedge clk);
		tracking_mode_select = sel;
		number_of_valid_blobs = 5'(nvb);
		enable_tracking_output = 1'b1;
		while (tracking_done !== 1'b1)
			@(negedge clk);

		check_value("number_of_bytes_to_transmit", 32'(4 * s + 4),
			32'(number_of_bytes_to_transmit));
		check_value("tracking_display", 32'(exp_display), 32'(tracking_display));
		for (int a = 0; a < 4 * s + 4; a++) begin
			tracking_output_addr_b = buf_addr_t'(a);
			@(negedge clk);   // read data is registered
			check_value($sformatf("tracking_output_data_read_b[%0d]", a), 32'(exp_pkt[a]),
				32'(tracking_output_data_read_b));
		end

		enable_tracking_output = 1'b0;
		repeat (2) @(negedge clk);
		check_value("tracking_done", 32'd0, 32'(tracking_done));
		check_value("tracking_display", 32'd0, 32'(tracking_display));
	endtask

	initial begin
		seed = 78;
		cycles = 0;
		checks = 0;
		errors = 0;
		reset = 1'b1;
		enable_tracking_output = 1'b0;
		tracking_mode_select = 2'b01;
		number_of_valid_blobs = '0;
		tracking_output_addr_b = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("tracking_done", 32'd0, 32'(tracking_done));
		check_value("tracking_display", 32'd0, 32'(tracking_display));

		run_case(2'b01, 31, 0);   // mode 1, every slot valid
		run_case(2'b10, 31, 5);   // mode 2 with empty slots
		run_case(2'b00, 4, 4);    // count stops the scan early
		run_case(2'b01, 3, 6);
		run_case(2'b11, 31, 3);   // replaces the short packet before it

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/tracking_pkg.sv
verilog/tracking_buffer.sv
verilog/color_tracker.sv
blob_fetch/blob_fetcher.sv
packet_writer/packet_writer.sv
verilog/tracking_output_assembly.sv
tests/blob_memory_model.sv
tests/tb_tracking_output.sv

// ==== Makefile ====
TOP = tb_tracking_output

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -o sim -f vlog.f

run: compile
	out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
